// ==== rtl/mem_pkg.sv ====
`default_nettype none

package mem_pkg;

    // array geometry
    localparam int INDEX_W     = 10;              // word index width
    localparam int MEM_DEPTH   = 1 << INDEX_W;    // 1024 words, so index math wraps by itself
    localparam int WORD_W      = 64;
    localparam int BURST_WORDS = 8;               // words per line
    localparam int LINE_W      = BURST_WORDS * WORD_W;

    // latency values, in clock cycles
    localparam int LAT_W = 8;
    localparam logic [LAT_W-1:0] SINGLE_LAT_RESET = 8'd64;
    localparam logic [LAT_W-1:0] BURST_LAT_RESET  = 8'd80;

    typedef logic [WORD_W-1:0] word_t;
    typedef logic [LINE_W-1:0] line_t;   // word k sits at bits 64k upward

    // word client command, 139 bits
    typedef struct packed {
        logic [INDEX_W-1:0] index;
        logic               write;
        word_t              mask;    // 1 = bit is written
        word_t              data;
    } word_req_t;

    // line client command, 523 bits
    typedef struct packed {
        logic [INDEX_W-1:0] index;   // first word of the line
        logic               write;
        line_t              data;
    } line_req_t;

    // which latency register a config strobe loads
    typedef enum logic {
        cfg_single = 1'b0,
        cfg_burst  = 1'b1
    } cfg_sel_e;

endpackage

`default_nettype wire

// ==== rtl/client_if.sv ====
`timescale 1ns/1ps
`default_nettype none

// client port <-> arbiter, one four-phase channel
interface client_if #(
    parameter type req_t = logic,
    parameter type rsp_t = logic
) ();
    logic req;
    logic ack;
    req_t cmd;   // held stable while req is high
    rsp_t rsp;   // valid from ack rise

    modport port (output req, cmd, input ack, rsp);
    modport arb  (input req, cmd, output ack, rsp);
endinterface

// arbiter <-> memory model
interface ddr_cmd_if
    import mem_pkg::*;
();
    logic               req;
    logic               ack;
    logic               burst;   // 1 = eight-word line access
    logic               write;
    logic [INDEX_W-1:0] index;
    word_t              wmask;   // word writes only
    line_t              wdata;   // word data rides in the low 64 bits
    line_t              rdata;

    modport ctrl (output req, burst, write, index, wmask, wdata, input ack, rdata);
    modport mem  (input req, burst, write, index, wmask, wdata, output ack, rdata);
endinterface

`default_nettype wire

// ==== rtl/client_port.sv ====
`timescale 1ns/1ps
`default_nettype none

// registered four-phase bridge between a top-level client and the arbiter
module client_port #(
    parameter type req_t = logic,
    parameter type rsp_t = logic
) (
    input  wire          clock,
    input  wire          reset_n,
    input  wire          host_req,
    input  wire req_t    host_cmd,
    output logic         host_ack,
    output rsp_t         host_rsp,
    client_if.port       arb
);

    typedef enum logic [1:0] {
        st_idle,          // waiting for host_req
        st_wait_ack,      // internal req up, waiting for arbiter ack
        st_wait_release,  // host ack up, waiting for host to drop req
        st_wait_drop      // internal req down, waiting for ack to fall
    } state_e;

    state_e state;
    logic   int_req;
    req_t   cmd_q;   // frozen copy of the host command
    rsp_t   rsp_q;

    always_ff @(posedge clock or negedge reset_n) begin
        if (!reset_n) begin
            state    <= st_idle;
            int_req  <= 1'b0;
            host_ack <= 1'b0;
        end else begin
            case (state)
                st_idle: if (host_req) begin
                    int_req <= 1'b1;          // forward next cycle
                    state   <= st_wait_ack;
                end
                st_wait_ack: if (arb.ack) begin
                    host_ack <= 1'b1;
                    state    <= st_wait_release;
                end
                st_wait_release: if (!host_req) begin
                    int_req <= 1'b0;
                    state   <= st_wait_drop;
                end
                st_wait_drop: if (!arb.ack) begin
                    host_ack <= 1'b0;         // host may raise req again after this
                    state    <= st_idle;
                end
                default: state <= st_idle;
            endcase
        end
    end

    // command latched once, top inputs may move afterwards
    always_ff @(posedge clock) begin
        if (state == st_idle && host_req) cmd_q <= host_cmd;
    end

    // response grabbed on ack rise, held until the next one
    always_ff @(posedge clock) begin
        if (state == st_wait_ack && arb.ack) rsp_q <= arb.rsp;
    end

    assign arb.req  = int_req;
    assign arb.cmd  = cmd_q;
    assign host_rsp = rsp_q;

endmodule

`default_nettype wire

// ==== rtl/mem_arbiter.sv ====
`timescale 1ns/1ps
`default_nettype none

// round-robin between line and word clients, one command at a time
module mem_arbiter
    import mem_pkg::*;
(
    input  wire      clock,
    input  wire      reset_n,
    client_if.arb    line,   // line_req_t / line_t
    client_if.arb    word,   // word_req_t / word_t
    ddr_cmd_if.ctrl  mem
);

    logic granted;     // a client owns the memory
    logic sel_line;    // owner, 1 = line client, kept after release as the last grant
    logic pick_line;
    logic sel_req;
    logic release_grant;

    // with both asking, the one not served last wins
    assign pick_line = line.req && (!word.req || !sel_line);

    assign sel_req       = sel_line ? line.req : word.req;
    assign release_grant = granted && !sel_req && !mem.ack;   // handshake fully closed

    always_ff @(posedge clock or negedge reset_n) begin
        if (!reset_n) begin
            granted  <= 1'b0;
            sel_line <= 1'b0;
        end else if (!granted) begin
            if (line.req || word.req) begin
                granted  <= 1'b1;
                sel_line <= pick_line;
            end
        end else if (release_grant) begin
            granted <= 1'b0;
        end
    end

    // command mux toward the model
    always_comb begin
        mem.req = granted && sel_req;
        if (sel_line) begin
            mem.burst = 1'b1;
            mem.write = line.cmd.write;
            mem.index = line.cmd.index;
            mem.wmask = '1;                 // lines are always written whole
            mem.wdata = line.cmd.data;
        end else begin
            mem.burst = 1'b0;
            mem.write = word.cmd.write;
            mem.index = word.cmd.index;
            mem.wmask = word.cmd.mask;
            mem.wdata = line_t'(word.cmd.data);   // low word, upper bits zero
        end
    end

    // ack only reaches the owner, data goes to both
    assign line.ack = granted && sel_line && mem.ack;
    assign word.ack = granted && !sel_line && mem.ack;
    assign line.rsp = mem.rdata;
    assign word.rsp = mem.rdata[WORD_W-1:0];

endmodule

`default_nettype wire

// ==== rtl/ddr_timing_regs.sv ====
`timescale 1ns/1ps
`default_nettype none

// single and burst latency registers, loaded by a one-cycle strobe
module ddr_timing_regs
    import mem_pkg::*;
(
    input  wire                   clock,
    input  wire                   reset_n,
    input  wire                   cfg_write,
    input  wire cfg_sel_e         cfg_sel,
    input  wire [LAT_W-1:0]       cfg_data,
    output logic [LAT_W-1:0]      single_lat,
    output logic [LAT_W-1:0]      burst_lat
);

    logic [LAT_W-1:0] load_val;

    // zero would mean no wait at all, clamp to one cycle
    assign load_val = (cfg_data == '0) ? LAT_W'(1) : cfg_data;

    always_ff @(posedge clock or negedge reset_n) begin
        if (!reset_n) begin
            single_lat <= SINGLE_LAT_RESET;
            burst_lat  <= BURST_LAT_RESET;
        end else if (cfg_write) begin
            if (cfg_sel == cfg_burst) burst_lat <= load_val;
            else                      single_lat <= load_val;
        end
    end

endmodule

`default_nettype wire

// ==== rtl/ddr_model.sv ====
`timescale 1ns/1ps
`default_nettype none

// main memory with programmable access latency
// one command in flight, performed L cycles after acceptance
module ddr_model
    import mem_pkg::*;
(
    input  wire               clock,
    input  wire               reset_n,
    input  wire [LAT_W-1:0]   single_lat,
    input  wire [LAT_W-1:0]   burst_lat,
    ddr_cmd_if.mem            cmd
);

    word_t mem_q [MEM_DEPTH] = '{default: '0};   // array starts cleared

    logic               busy;        // command held, counting down
    logic               ack_q;
    logic [LAT_W-1:0]   count_q;     // cycles left until the access
    logic               accept;
    logic               last_cycle;  // access happens on this edge

    // latched command
    logic [INDEX_W-1:0] index_q;
    logic               write_q;
    logic               burst_q;
    word_t              wmask_q;
    line_t              wdata_q;
    line_t              rdata_q;

    // word k of a line, wrapping at the top of the array
    function automatic logic [INDEX_W-1:0] line_index(input logic [INDEX_W-1:0] base,
                                                      input int k);
        return INDEX_W'(base + INDEX_W'(k));
    endfunction

    assign accept     = !busy && !ack_q && cmd.req;
    assign last_cycle = busy && (count_q == LAT_W'(1));

    always_ff @(posedge clock or negedge reset_n) begin
        if (!reset_n) begin
            busy    <= 1'b0;
            ack_q   <= 1'b0;
            count_q <= '0;
        end else if (accept) begin
            busy    <= 1'b1;
            count_q <= cmd.burst ? burst_lat : single_lat;   // latency fixed at accept
        end else if (busy) begin
            if (last_cycle) begin
                busy  <= 1'b0;
                ack_q <= 1'b1;   // same edge as the access
            end else begin
                count_q <= count_q - 1'b1;
            end
        end else if (ack_q && !cmd.req) begin
            ack_q <= 1'b0;
        end
    end

    always_ff @(posedge clock) begin
        if (accept) begin
            index_q <= cmd.index;
            write_q <= cmd.write;
            burst_q <= cmd.burst;
            wmask_q <= cmd.wmask;
            wdata_q <= cmd.wdata;
        end
    end

    // the access itself
    always_ff @(posedge clock) begin
        if (last_cycle) begin
            if (burst_q) begin
                for (int k = 0; k < BURST_WORDS; k++) begin
                    if (write_q) mem_q[line_index(index_q, k)] <= wdata_q[k*WORD_W +: WORD_W];
                    else rdata_q[k*WORD_W +: WORD_W] <= mem_q[line_index(index_q, k)];
                end
            end else if (write_q) begin
                // only masked bits change
                mem_q[index_q] <= (mem_q[index_q] & ~wmask_q)
                                | (wdata_q[WORD_W-1:0] & wmask_q);
            end else begin
                rdata_q <= line_t'(mem_q[index_q]);   // word in low bits
            end
        end
    end

    assign cmd.ack   = ack_q;
    assign cmd.rdata = rdata_q;   // stable until the next read completes

endmodule

`default_nettype wire

// ==== rtl/mem_subsystem.sv ====
`timescale 1ns/1ps
`default_nettype none

// two clients, one arbiter, one latency-modelled memory
module mem_subsystem
    import mem_pkg::*;
(
    input  wire                 clock,
    input  wire                 reset_n,

    // latency config strobe
    input  wire                 cfg_write,
    input  wire cfg_sel_e       cfg_sel,
    input  wire [LAT_W-1:0]     cfg_data,

    // line client
    input  wire                 line_req,
    input  wire                 line_write,
    input  wire [INDEX_W-1:0]   line_index,
    input  wire line_t          line_wdata,
    output logic                line_ack,
    output line_t               line_rdata,

    // word client
    input  wire                 word_req,
    input  wire                 word_write,
    input  wire [INDEX_W-1:0]   word_index,
    input  wire word_t          word_wmask,
    input  wire word_t          word_wdata,
    output logic                word_ack,
    output word_t               word_rdata
);

    line_req_t        line_cmd;
    word_req_t        word_cmd;
    logic [LAT_W-1:0] single_lat;
    logic [LAT_W-1:0] burst_lat;

    assign line_cmd = '{index: line_index, write: line_write, data: line_wdata};
    assign word_cmd = '{index: word_index, write: word_write, mask: word_wmask,
                        data: word_wdata};

    client_if #(.req_t(line_req_t), .rsp_t(line_t)) line_if ();
    client_if #(.req_t(word_req_t), .rsp_t(word_t)) word_if ();
    ddr_cmd_if ddr_if ();

    client_port #(.req_t(line_req_t), .rsp_t(line_t)) line_port0 (
        .clock    (clock),
        .reset_n  (reset_n),
        .host_req (line_req),
        .host_cmd (line_cmd),
        .host_ack (line_ack),
        .host_rsp (line_rdata),
        .arb      (line_if.port)
    );

    client_port #(.req_t(word_req_t), .rsp_t(word_t)) word_port0 (
        .clock    (clock),
        .reset_n  (reset_n),
        .host_req (word_req),
        .host_cmd (word_cmd),
        .host_ack (word_ack),
        .host_rsp (word_rdata),
        .arb      (word_if.port)
    );

    mem_arbiter arbiter0 (
        .clock   (clock),
        .reset_n (reset_n),
        .line    (line_if.arb),
        .word    (word_if.arb),
        .mem     (ddr_if.ctrl)
    );

    ddr_timing_regs timing0 (
        .clock      (clock),
        .reset_n    (reset_n),
        .cfg_write  (cfg_write),
        .cfg_sel    (cfg_sel),
        .cfg_data   (cfg_data),
        .single_lat (single_lat),
        .burst_lat  (burst_lat)
    );

    ddr_model model0 (
        .clock      (clock),
        .reset_n    (reset_n),
        .single_lat (single_lat),
        .burst_lat  (burst_lat),
        .cmd        (ddr_if.mem)
    );

endmodule

`default_nettype wire

// ==== verification/mem_subsystem_tb.sv ====
`timescale 1ns/1ps
`default_nettype none

module mem_subsystem_tb
    import mem_pkg::*;
();

    localparam int TIMEOUT = 400;   // cycles per wait, well above 80 plus overhead
    localparam int SLACK   = 12;    // fixed overhead allowed above the latency
    localparam int N_TESTS = 19;

    typedef enum logic [1:0] {op_word, op_line, op_pair} op_e;

    // one table row, count > 1 repeats the op on consecutive indices
    typedef struct packed {
        op_e                kind;
        logic               write;
        logic [INDEX_W-1:0] index;    // word index, or line index of a line op
        logic [INDEX_W-1:0] index2;   // line index of a pair
        logic [3:0]         count;
        logic               rnd;      // random mask and data
        logic [LAT_W-1:0]   lat;      // latency to program first, 0 = keep
    } entry_t;

    entry_t tests [N_TESTS] = '{
        '{op_word, 1'b0, 10'd5,    10'd0,   4'd1, 1'b0, 8'd0},   // first word read, 64
        '{op_line, 1'b0, 10'd16,   10'd0,   4'd1, 1'b0, 8'd0},   // first line read, 80
        '{op_word, 1'b1, 10'd37,   10'd0,   4'd1, 1'b0, 8'd0},   // full mask fill
        '{op_word, 1'b1, 10'd37,   10'd0,   4'd1, 1'b1, 8'd0},   // masked overwrite
        '{op_word, 1'b0, 10'd37,   10'd0,   4'd1, 1'b0, 8'd0},
        '{op_line, 1'b1, 10'd100,  10'd0,   4'd1, 1'b1, 8'd0},
        '{op_word, 1'b0, 10'd100,  10'd0,   4'd8, 1'b0, 8'd0},   // line back word by word
        '{op_line, 1'b1, 10'd1021, 10'd0,   4'd1, 1'b1, 8'd0},   // wraps onto 0..4
        '{op_word, 1'b0, 10'd1021, 10'd0,   4'd8, 1'b0, 8'd0},
        '{op_word, 1'b1, 10'd200,  10'd0,   4'd8, 1'b1, 8'd0},
        '{op_line, 1'b0, 10'd200,  10'd0,   4'd1, 1'b0, 8'd0},   // words back as a line
        '{op_pair, 1'b1, 10'd300,  10'd400, 4'd1, 1'b1, 8'd0},   // both clients at once
        '{op_pair, 1'b0, 10'd300,  10'd400, 4'd1, 1'b0, 8'd0},
        '{op_word, 1'b0, 10'd37,   10'd0,   4'd1, 1'b0, 8'd5},   // short single latency
        '{op_line, 1'b0, 10'd100,  10'd0,   4'd1, 1'b0, 8'd9},   // short burst latency
        '{op_word, 1'b1, 10'd500,  10'd0,   4'd1, 1'b1, 8'd0},
        '{op_word, 1'b0, 10'd500,  10'd0,   4'd1, 1'b0, 8'd0},
        '{op_line, 1'b1, 10'd600,  10'd0,   4'd1, 1'b1, 8'd0},
        '{op_line, 1'b0, 10'd600,  10'd0,   4'd1, 1'b0, 8'd0}
    };

    logic               clock, reset_n, cfg_write;
    cfg_sel_e           cfg_sel;
    logic [LAT_W-1:0]   cfg_data;
    logic               line_req, line_write, line_ack;
    logic [INDEX_W-1:0] line_index;
    line_t              line_wdata, line_rdata;
    logic               word_req, word_write, word_ack;
    logic [INDEX_W-1:0] word_index;
    word_t              word_wmask, word_wdata, word_rdata;

    word_t       shadow [MEM_DEPTH] = '{default: '0};   // expected memory contents
    logic [31:0] lfsr_state = 32'hc5bc;
    int          errors, passed, failed;
    int          cur_single = 64;     // latencies the DUT should be using
    int          cur_burst  = 80;
    time         word_ack_t, line_ack_t;   // negedge on which each ack was seen

    mem_subsystem dut0 (
        .clock(clock), .reset_n(reset_n),
        .cfg_write(cfg_write), .cfg_sel(cfg_sel), .cfg_data(cfg_data),
        .line_req(line_req), .line_write(line_write), .line_index(line_index),
        .line_wdata(line_wdata), .line_ack(line_ack), .line_rdata(line_rdata),
        .word_req(word_req), .word_write(word_write), .word_index(word_index),
        .word_wmask(word_wmask), .word_wdata(word_wdata),
        .word_ack(word_ack), .word_rdata(word_rdata)
    );

    initial begin
        clock = 1'b0;
        forever #4 clock = ~clock;   // 8 ns period
    end

    // galois form, taps x^32 + x^22 + x^2 + x + 1
    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        return s[0] ? ((s >> 1) ^ 32'h8020_0003) : (s >> 1);
    endfunction

    task automatic rand_word(output word_t w);
        for (int b = 0; b < WORD_W; b++) begin
            w[b]       = lfsr_state[0];   // one step per bit
            lfsr_state = lfsr_next(lfsr_state);
        end
    endtask

    // deterministic data, every index bit shows up twice
    function automatic word_t fill_word(input int idx);
        logic [INDEX_W-1:0] a;
        a = idx[INDEX_W-1:0];
        return {22'h1a5a5a, a, 22'h2c3c3c, ~a};
    endfunction

    task automatic check(input line_t got, input line_t exp, input string msg);
        if (got !== exp) begin
            $display("CHECK FAILED at %0t ns: %s, got %h expected %h", $time, msg, got, exp);
            errors++;
        end
    endtask

    task automatic give_up(input string what);
        $display("timeout: %s within %0d cycles at %0t ns", what, TIMEOUT, $time);
        $display("TESTS FAILED");
        $finish;
    endtask

    task automatic program_lat(input cfg_sel_e sel, input logic [LAT_W-1:0] value);
        cfg_write = 1'b1;
        cfg_sel   = sel;
        cfg_data  = value;
        @(negedge clock);
        cfg_write = 1'b0;   // single-cycle strobe
    endtask

    // full four-phase word transaction, entered and left on a falling edge
    task automatic word_op(input logic write, input int idx, input word_t mask,
                           input word_t data, output word_t rdata, output int cycles);
        int n;
        word_req   = 1'b1;
        word_write = write;
        word_index = idx[INDEX_W-1:0];
        word_wmask = mask;
        word_wdata = data;
        cycles     = 0;
        while (!word_ack) begin
            @(negedge clock);
            cycles++;
            if (cycles > TIMEOUT) give_up("the word client ack never rose");
        end
        rdata      = word_rdata;
        word_ack_t = $time;
        word_req   = 1'b0;   // release on the same falling edge
        n = 0;
        while (word_ack) begin
            @(negedge clock);
            n++;
            if (n > TIMEOUT) give_up("the word client ack never fell");
        end
    endtask

    task automatic line_op(input logic write, input int idx, input line_t data,
                           output line_t rdata, output int cycles);
        int n;
        line_req   = 1'b1;
        line_write = write;
        line_index = idx[INDEX_W-1:0];
        line_wdata = data;
        cycles     = 0;
        while (!line_ack) begin
            @(negedge clock);
            cycles++;
            if (cycles > TIMEOUT) give_up("the line client ack never rose");
        end
        rdata      = line_rdata;
        line_ack_t = $time;
        line_req   = 1'b0;
        n = 0;
        while (line_ack) begin
            @(negedge clock);
            n++;
            if (n > TIMEOUT) give_up("the line client ack never fell");
        end
    endtask

    // tight = no competing client, so the upper bound applies too
    task automatic run_word(input logic write, input logic rnd, input int idx, input logic tight);
        word_t mask, data, got;
        int    cycles;
        if (rnd) begin
            rand_word(mask);
            rand_word(data);
        end else begin
            mask = '1;
            data = fill_word(idx);
        end
        word_op(write, idx, mask, data, got, cycles);
        if (write) begin
            for (int b = 0; b < WORD_W; b++) begin
                if (mask[b]) shadow[idx][b] = data[b];   // unmasked bits keep the old value
            end
        end else begin
            check(got, shadow[idx], $sformatf("word read at %0d", idx));
        end
        check(cycles >= cur_single, 1'b1, $sformatf("word ack after %0d cycles", cycles));
        if (tight) check(cycles <= cur_single + SLACK, 1'b1,
                         $sformatf("word ack late, %0d cycles", cycles));
    endtask

    task automatic run_line(input logic write, input logic rnd, input int idx, input logic tight);
        line_t data, exp, got;
        word_t w;
        int    cycles;
        for (int k = 0; k < BURST_WORDS; k++) begin
            if (rnd) rand_word(w);
            else     w = fill_word((idx + k) % MEM_DEPTH);
            data[k*WORD_W +: WORD_W] = w;
            exp[k*WORD_W +: WORD_W]  = shadow[(idx + k) % MEM_DEPTH];   // word k at index+k
        end
        line_op(write, idx, data, got, cycles);
        if (write) begin
            for (int k = 0; k < BURST_WORDS; k++) begin
                shadow[(idx + k) % MEM_DEPTH] = data[k*WORD_W +: WORD_W];
            end
        end else begin
            check(got, exp, $sformatf("line read at %0d", idx));
        end
        check(cycles >= cur_burst, 1'b1, $sformatf("line ack after %0d cycles", cycles));
        if (tight) check(cycles <= cur_burst + SLACK, 1'b1,
                         $sformatf("line ack late, %0d cycles", cycles));
    endtask

    initial begin
        entry_t e;
        int     idx, errs_before, lat2;
        time    first, second;
        {cfg_write, line_req, line_write, word_req, word_write} = '0;
        cfg_sel    = cfg_single;
        cfg_data   = '0;
        line_index = '0;
        line_wdata = '0;
        word_index = '0;
        word_wmask = '0;
        word_wdata = '0;
        reset_n    = 1'b0;
        repeat (2) @(negedge clock);
        reset_n = 1'b1;
        check(line_ack, 1'b0, "line ack high after reset");
        check(word_ack, 1'b0, "word ack high after reset");
        if (errors == 0) passed++;
        else             failed++;
        $display("test  r reset: %s", (errors == 0) ? "pass" : "fail");
        @(negedge clock);

        for (int t = 0; t < N_TESTS; t++) begin
            e = tests[t];
            errs_before = errors;
            if (e.lat != 0 && e.kind == op_line) begin
                program_lat(cfg_burst, e.lat);
                cur_burst = e.lat;
            end else if (e.lat != 0) begin
                program_lat(cfg_single, e.lat);
                cur_single = e.lat;
            end
            for (int j = 0; j < e.count; j++) begin
                idx = (e.index + j) % MEM_DEPTH;
                case (e.kind)
                    op_word: run_word(e.write, e.rnd, idx, 1'b1);
                    op_line: run_line(e.write, e.rnd, idx, 1'b1);
                    default: begin
                        fork
                            run_word(e.write, e.rnd, idx, 1'b0);
                            run_line(e.write, e.rnd, int'(e.index2), 1'b0);
                        join
                        // the loser still waits its whole latency after the winner lets go
                        first  = (word_ack_t < line_ack_t) ? word_ack_t : line_ack_t;
                        second = (word_ack_t < line_ack_t) ? line_ack_t : word_ack_t;
                        lat2   = (word_ack_t < line_ack_t) ? cur_burst : cur_single;
                        check((second - first) >= 8 * lat2, 1'b1, "second ack came too soon");
                    end
                endcase
                @(negedge clock);   // idle cycle between commands
            end
            if (errors == errs_before) passed++;
            else                       failed++;
            $display("test %2d %s %s x%0d at %0d: %s", t, e.kind.name(),
                     e.write ? "write" : "read", e.count, e.index,
                     (errors == errs_before) ? "pass" : "fail");
        end

        $display("%0d tests passed, %0d failed, %0d check errors", passed, failed, errors);
        if (failed == 0 && errors == 0) begin
            $display("TESTS PASSED");
        end else begin
            $display("TESTS FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== files.f ====
rtl/mem_pkg.sv
rtl/client_if.sv
rtl/client_port.sv
rtl/mem_arbiter.sv
rtl/ddr_timing_regs.sv
rtl/ddr_model.sv
rtl/mem_subsystem.sv
verification/mem_subsystem_tb.sv
